/* verilog/periph_pkg.sv */
package periph_pkg;

    // --------------------------------------------------
    // Access port and register widths
    // --------------------------------------------------
    localparam int ADDR_WIDTH   = 16;
    localparam int DATA_WIDTH   = 32;
    localparam int OFFSET_WIDTH = 12;

    // --------------------------------------------------
    // Interrupt layout
    // --------------------------------------------------
    // Id 0 is reserved for "no interrupt"
    localparam int NUM_SOURCES    = 7;
    localparam int NUM_TARGETS    = 2;
    localparam int PRIO_WIDTH     = 3;
    localparam int ID_WIDTH       = $clog2(NUM_SOURCES + 1);
    localparam int NUM_TIMERS     = 2;
    localparam int NUM_EXT_IRQ    = 5;
    localparam int TIMER_IRQ_BASE = 1;
    localparam int EXT_IRQ_BASE   = 3;

    // Read data of every error response
    localparam logic [DATA_WIDTH-1:0] ERR_RDATA = 32'hdeadbeef;

    // PLIC register map
    localparam int PLIC_PRIO_OFS = 'h000;
    localparam int PLIC_PEND_OFS = 'h080;
    localparam int PLIC_EN_OFS   = 'h100;
    localparam int PLIC_CTX_OFS  = 'h200;

    // Timer register map, one block of registers per timer
    localparam int TIMER_STRIDE   = 'h10;
    localparam int TIMER_CNT_OFS  = 'h0;
    localparam int TIMER_CTRL_OFS = 'h4;
    localparam int TIMER_CMP_OFS  = 'h8;
    localparam int TIMER_STAT_OFS = 'hC;

    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [OFFSET_WIDTH-1:0] offset_t;
    typedef logic [PRIO_WIDTH-1:0]   prio_t;
    typedef logic [ID_WIDTH-1:0]     id_t;

    // Region is taken from the address bits above the offset
    typedef enum logic [ADDR_WIDTH-OFFSET_WIDTH-1:0] {
        REGION_PLIC  = 'd0,
        REGION_TIMER = 'd1,
        REGION_SPI   = 'd2,
        REGION_ETH   = 'd3,
        REGION_DMA   = 'd4,
        REGION_IOMMU = 'd5
    } region_e;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESPOND
    } bridge_state_e;

endpackage

/* verilog/reg_bus_if.sv */
`timescale 1ns/1ps

// Single-cycle register access from the bridge to one peripheral
interface reg_bus_if;

    logic                  valid;
    logic                  write;
    periph_pkg::offset_t   addr;
    periph_pkg::data_t     wdata;
    periph_pkg::data_t     rdata;
    logic                  err;

    modport bridge (
        output valid,
        output write,
        output addr,
        output wdata,
        input  rdata,
        input  err
    );

    // Peripheral answers combinationally in the cycle valid is high
    modport periph (
        input  valid,
        input  write,
        input  addr,
        input  wdata,
        output rdata,
        output err
    );

endinterface

/* verilog/periph_bridge.sv */
`timescale 1ns/1ps

module periph_bridge (
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  logic                              req_valid_i,
    input  logic                              req_write_i,
    input  logic [periph_pkg::ADDR_WIDTH-1:0] req_addr_i,
    input  logic [periph_pkg::DATA_WIDTH-1:0] req_wdata_i,
    output logic                              req_ready_o,
    output logic                              rsp_valid_o,
    input  logic                              rsp_ready_i,
    output logic [periph_pkg::DATA_WIDTH-1:0] rsp_rdata_o,
    output logic                              rsp_err_o,
    reg_bus_if.bridge                         plic_bus,
    reg_bus_if.bridge                         timer_bus
);

    periph_pkg::bridge_state_e state_q;
    periph_pkg::region_e       region_q;
    logic                      write_q;
    periph_pkg::offset_t       offset_q;
    periph_pkg::data_t         wdata_q;
    periph_pkg::data_t         rsp_rdata_q;
    logic                      rsp_err_q;

    logic                      sel_plic;
    logic                      sel_timer;
    logic                      acc_err;
    periph_pkg::data_t         acc_rdata;

    // --------------------------------------------------
    // Handshake FSM
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= periph_pkg::IDLE;
        end else begin
            case (state_q)
                periph_pkg::IDLE:    if (req_valid_i) state_q <= periph_pkg::ACCESS;
                periph_pkg::ACCESS:  state_q <= periph_pkg::RESPOND;
                periph_pkg::RESPOND: if (rsp_ready_i) state_q <= periph_pkg::IDLE;
                default:             state_q <= periph_pkg::IDLE;
            endcase
        end
    end

    assign req_ready_o = (state_q == periph_pkg::IDLE);
    assign rsp_valid_o = (state_q == periph_pkg::RESPOND);

    // Request and response payload
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            write_q     <= 1'b0;
            region_q    <= periph_pkg::REGION_PLIC;
            offset_q    <= '0;
            wdata_q     <= '0;
            rsp_err_q   <= 1'b0;
            rsp_rdata_q <= '0;
        end else begin
            if (state_q == periph_pkg::IDLE && req_valid_i) begin
                write_q  <= req_write_i;
                region_q <= periph_pkg::region_e'(
                    req_addr_i[periph_pkg::ADDR_WIDTH-1:periph_pkg::OFFSET_WIDTH]);
                offset_q <= req_addr_i[periph_pkg::OFFSET_WIDTH-1:0];
                wdata_q  <= req_wdata_i;
            end
            if (state_q == periph_pkg::ACCESS) begin
                rsp_err_q   <= acc_err;
                rsp_rdata_q <= acc_err ? periph_pkg::ERR_RDATA : (write_q ? '0 : acc_rdata);
            end
        end
    end

    assign rsp_rdata_o = rsp_rdata_q;
    assign rsp_err_o   = rsp_err_q;

    // --------------------------------------------------
    // Region decode
    // --------------------------------------------------
    always_comb begin
        sel_plic  = 1'b0;
        sel_timer = 1'b0;
        case (region_q)
            periph_pkg::REGION_PLIC:  sel_plic  = 1'b1;
            periph_pkg::REGION_TIMER: sel_timer = 1'b1;
            // Peripherals not present in this subsystem answer with an error
            periph_pkg::REGION_SPI, periph_pkg::REGION_ETH,
            periph_pkg::REGION_DMA, periph_pkg::REGION_IOMMU: ;
            default: ;
        endcase
    end

    always_comb begin
        acc_err   = 1'b1;
        acc_rdata = '0;
        if (sel_plic) begin
            acc_err   = plic_bus.err;
            acc_rdata = plic_bus.rdata;
        end else if (sel_timer) begin
            acc_err   = timer_bus.err;
            acc_rdata = timer_bus.rdata;
        end
    end

    assign plic_bus.valid  = (state_q == periph_pkg::ACCESS) && sel_plic;
    assign plic_bus.write  = write_q;
    assign plic_bus.addr   = offset_q;
    assign plic_bus.wdata  = wdata_q;

    assign timer_bus.valid = (state_q == periph_pkg::ACCESS) && sel_timer;
    assign timer_bus.write = write_q;
    assign timer_bus.addr  = offset_q;
    assign timer_bus.wdata = wdata_q;

endmodule

/* verilog/periph_plic.sv */
`timescale 1ns/1ps

module periph_plic (
    input  logic                               clk_i,
    input  logic                               rst_i,
    reg_bus_if.periph                          bus,
    input  logic [periph_pkg::NUM_SOURCES-1:0] irq_sources_i,
    output logic [periph_pkg::NUM_TARGETS-1:0] irq_o
);

    // Per-id state is indexed by the id itself
    periph_pkg::prio_t                   prio_q      [1:periph_pkg::NUM_SOURCES];
    logic [periph_pkg::NUM_SOURCES:1]    pending_q;
    logic [periph_pkg::NUM_SOURCES:1]    claimed_q;
    logic [periph_pkg::NUM_SOURCES:1]    enable_q    [periph_pkg::NUM_TARGETS];
    periph_pkg::prio_t                   threshold_q [periph_pkg::NUM_TARGETS];
    logic [periph_pkg::NUM_TARGETS-1:0]  irq_q;

    periph_pkg::id_t                     best_id     [periph_pkg::NUM_TARGETS];
    periph_pkg::prio_t                   best_prio   [periph_pkg::NUM_TARGETS];
    periph_pkg::id_t                     done_id;

    logic                                wr_en;
    logic                                rd_en;
    logic [periph_pkg::NUM_SOURCES:1]    prio_we;
    logic [periph_pkg::NUM_TARGETS-1:0]  en_we;
    logic [periph_pkg::NUM_TARGETS-1:0]  thr_we;
    logic [periph_pkg::NUM_TARGETS-1:0]  claim_re;
    logic [periph_pkg::NUM_TARGETS-1:0]  done_we;

    assign wr_en   = bus.valid && bus.write;
    assign rd_en   = bus.valid && !bus.write;
    assign done_id = bus.wdata[periph_pkg::ID_WIDTH-1:0];

    // --------------------------------------------------
    // Register decode
    // --------------------------------------------------
    always_comb begin
        bus.rdata = '0;
        bus.err   = 1'b1;
        prio_we   = '0;
        en_we     = '0;
        thr_we    = '0;
        claim_re  = '0;
        done_we   = '0;
        for (int n = 1; n <= periph_pkg::NUM_SOURCES; n++) begin
            if (bus.addr == periph_pkg::offset_t'(periph_pkg::PLIC_PRIO_OFS + 4 * n)) begin
                bus.err    = 1'b0;
                bus.rdata  = periph_pkg::data_t'(prio_q[n]);
                prio_we[n] = wr_en;
            end
        end
        // Pending is read-only, writes are dropped
        if (bus.addr == periph_pkg::offset_t'(periph_pkg::PLIC_PEND_OFS)) begin
            bus.err   = 1'b0;
            bus.rdata = periph_pkg::data_t'({pending_q, 1'b0});
        end
        for (int t = 0; t < periph_pkg::NUM_TARGETS; t++) begin
            if (bus.addr == periph_pkg::offset_t'(periph_pkg::PLIC_EN_OFS + 4 * t)) begin
                bus.err   = 1'b0;
                bus.rdata = periph_pkg::data_t'({enable_q[t], 1'b0});
                en_we[t]  = wr_en;
            end
            if (bus.addr == periph_pkg::offset_t'(periph_pkg::PLIC_CTX_OFS + 8 * t)) begin
                bus.err   = 1'b0;
                bus.rdata = periph_pkg::data_t'(threshold_q[t]);
                thr_we[t] = wr_en;
            end
            // Read claims, write completes
            if (bus.addr == periph_pkg::offset_t'(periph_pkg::PLIC_CTX_OFS + 8 * t + 4)) begin
                bus.err     = 1'b0;
                bus.rdata   = periph_pkg::data_t'(best_id[t]);
                claim_re[t] = rd_en;
                done_we[t]  = wr_en;
            end
        end
    end

    // Highest enabled pending priority per target, lower id wins a tie
    always_comb begin
        for (int t = 0; t < periph_pkg::NUM_TARGETS; t++) begin
            best_id[t]   = '0;
            best_prio[t] = '0;
            for (int n = 1; n <= periph_pkg::NUM_SOURCES; n++) begin
                if (pending_q[n] && enable_q[t][n] && prio_q[n] > best_prio[t]) begin
                    best_id[t]   = periph_pkg::id_t'(n);
                    best_prio[t] = prio_q[n];
                end
            end
        end
    end

    // --------------------------------------------------
    // Gateways, claim/complete and target outputs
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int n = 1; n <= periph_pkg::NUM_SOURCES; n++) prio_q[n] <= '0;
            for (int t = 0; t < periph_pkg::NUM_TARGETS; t++) begin
                enable_q[t]    <= '0;
                threshold_q[t] <= '0;
            end
            pending_q <= '0;
            claimed_q <= '0;
            irq_q     <= '0;
        end else begin
            for (int n = 1; n <= periph_pkg::NUM_SOURCES; n++) begin
                if (prio_we[n]) prio_q[n] <= bus.wdata[periph_pkg::PRIO_WIDTH-1:0];
                // Level gateway holds off while the id is in service
                if (irq_sources_i[n-1] && !claimed_q[n]) pending_q[n] <= 1'b1;
            end
            for (int t = 0; t < periph_pkg::NUM_TARGETS; t++) begin
                if (en_we[t]) enable_q[t] <= bus.wdata[periph_pkg::NUM_SOURCES:1];
                if (thr_we[t]) threshold_q[t] <= bus.wdata[periph_pkg::PRIO_WIDTH-1:0];
                if (claim_re[t] && best_id[t] != '0) begin
                    pending_q[best_id[t]] <= 1'b0;
                    claimed_q[best_id[t]] <= 1'b1;
                end
                if (done_we[t] && done_id != '0) claimed_q[done_id] <= 1'b0;
                irq_q[t] <= best_prio[t] > threshold_q[t];
            end
        end
    end

    assign irq_o = irq_q;

endmodule

/* verilog/periph_timer.sv */
`timescale 1ns/1ps

module periph_timer (
    input  logic                              clk_i,
    input  logic                              rst_i,
    reg_bus_if.periph                         bus,
    output logic [periph_pkg::NUM_TIMERS-1:0] irq_o
);

    periph_pkg::data_t                  cnt_q  [periph_pkg::NUM_TIMERS];
    periph_pkg::data_t                  cmp_q  [periph_pkg::NUM_TIMERS];
    logic [periph_pkg::NUM_TIMERS-1:0]  en_q;
    logic [periph_pkg::NUM_TIMERS-1:0]  stat_q;

    logic                               wr_en;
    logic [periph_pkg::NUM_TIMERS-1:0]  cnt_we;
    logic [periph_pkg::NUM_TIMERS-1:0]  ctrl_we;
    logic [periph_pkg::NUM_TIMERS-1:0]  cmp_we;
    logic [periph_pkg::NUM_TIMERS-1:0]  stat_we;

    assign wr_en = bus.valid && bus.write;

    // --------------------------------------------------
    // Register decode
    // --------------------------------------------------
    always_comb begin
        bus.rdata = '0;
        bus.err   = 1'b1;
        cnt_we    = '0;
        ctrl_we   = '0;
        cmp_we    = '0;
        stat_we   = '0;
        for (int i = 0; i < periph_pkg::NUM_TIMERS; i++) begin
            if (bus.addr == periph_pkg::offset_t'(periph_pkg::TIMER_STRIDE * i
                                                  + periph_pkg::TIMER_CNT_OFS)) begin
                bus.err   = 1'b0;
                bus.rdata = cnt_q[i];
                cnt_we[i] = wr_en;
            end
            if (bus.addr == periph_pkg::offset_t'(periph_pkg::TIMER_STRIDE * i
                                                  + periph_pkg::TIMER_CTRL_OFS)) begin
                bus.err    = 1'b0;
                bus.rdata  = periph_pkg::data_t'(en_q[i]);
                ctrl_we[i] = wr_en;
            end
            if (bus.addr == periph_pkg::offset_t'(periph_pkg::TIMER_STRIDE * i
                                                  + periph_pkg::TIMER_CMP_OFS)) begin
                bus.err   = 1'b0;
                bus.rdata = cmp_q[i];
                cmp_we[i] = wr_en;
            end
            if (bus.addr == periph_pkg::offset_t'(periph_pkg::TIMER_STRIDE * i
                                                  + periph_pkg::TIMER_STAT_OFS)) begin
                bus.err    = 1'b0;
                bus.rdata  = periph_pkg::data_t'(stat_q[i]);
                stat_we[i] = wr_en;
            end
        end
    end

    // --------------------------------------------------
    // Counters
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < periph_pkg::NUM_TIMERS; i++) begin
                cnt_q[i] <= '0;
                cmp_q[i] <= '0;
            end
            en_q   <= '0;
            stat_q <= '0;
        end else begin
            for (int i = 0; i < periph_pkg::NUM_TIMERS; i++) begin
                if (stat_we[i] && bus.wdata[0]) stat_q[i] <= 1'b0;
                // Compare hit wraps the counter and raises the flag
                if (en_q[i] && cnt_q[i] == cmp_q[i]) begin
                    cnt_q[i]  <= '0;
                    stat_q[i] <= 1'b1;
                end else if (en_q[i]) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
                if (cnt_we[i]) cnt_q[i] <= bus.wdata;
                if (ctrl_we[i]) en_q[i] <= bus.wdata[0];
                if (cmp_we[i]) cmp_q[i] <= bus.wdata;
            end
        end
    end

    assign irq_o = stat_q;

endmodule

/* verilog/periph_top.sv */
`timescale 1ns/1ps

module periph_top (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic                               req_valid_i,
    output logic                               req_ready_o,
    input  logic                               req_write_i,
    input  logic [periph_pkg::ADDR_WIDTH-1:0]  req_addr_i,
    input  logic [periph_pkg::DATA_WIDTH-1:0]  req_wdata_i,
    output logic                               rsp_valid_o,
    input  logic                               rsp_ready_i,
    output logic [periph_pkg::DATA_WIDTH-1:0]  rsp_rdata_o,
    output logic                               rsp_err_o,
    input  logic [periph_pkg::NUM_EXT_IRQ-1:0] ext_irq_i,
    output logic [periph_pkg::NUM_TARGETS-1:0] irq_o
);

    logic [periph_pkg::NUM_TIMERS-1:0]  timer_irq;
    logic [periph_pkg::NUM_SOURCES-1:0] irq_sources;

    reg_bus_if plic_bus ();
    reg_bus_if timer_bus ();

    // Source vector bit n-1 carries id n
    assign irq_sources[periph_pkg::TIMER_IRQ_BASE-1 +: periph_pkg::NUM_TIMERS] = timer_irq;
    assign irq_sources[periph_pkg::EXT_IRQ_BASE-1 +: periph_pkg::NUM_EXT_IRQ]  = ext_irq_i;

    periph_bridge i_bridge (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .req_valid_i ( req_valid_i ),
        .req_write_i ( req_write_i ),
        .req_addr_i  ( req_addr_i  ),
        .req_wdata_i ( req_wdata_i ),
        .req_ready_o ( req_ready_o ),
        .rsp_valid_o ( rsp_valid_o ),
        .rsp_ready_i ( rsp_ready_i ),
        .rsp_rdata_o ( rsp_rdata_o ),
        .rsp_err_o   ( rsp_err_o   ),
        .plic_bus    ( plic_bus    ),
        .timer_bus   ( timer_bus   )
    );

    periph_plic i_plic (
        .clk_i         ( clk_i       ),
        .rst_i         ( rst_i       ),
        .bus           ( plic_bus    ),
        .irq_sources_i ( irq_sources ),
        .irq_o         ( irq_o       )
    );

    periph_timer i_timer (
        .clk_i ( clk_i     ),
        .rst_i ( rst_i     ),
        .bus   ( timer_bus ),
        .irq_o ( timer_irq )
    );

endmodule

/* verification/periph_chk.sv */
`timescale 1ns/1ps

module periph_chk (
    input logic                               clk_i,
    input logic                               rst_i,
    input logic                               req_valid_i,
    input logic                               req_ready_o,
    input logic                               rsp_valid_o,
    input logic                               rsp_ready_i,
    input logic [periph_pkg::DATA_WIDTH-1:0]  rsp_rdata_o,
    input logic                               rsp_err_o,
    input logic [periph_pkg::NUM_TARGETS-1:0] irq_o
);

    // --------------------------------------------------
    // Handshake rules
    // --------------------------------------------------
    // One ACCESS cycle, then RESPOND
    assert property (@(posedge clk_i) disable iff (rst_i)
        (req_valid_i && req_ready_o) |=> !rsp_valid_o ##1 rsp_valid_o)
        else $error("Response did not arrive two cycles after acceptance");

    assert property (@(posedge clk_i) disable iff (rst_i)
        (rsp_valid_o && !rsp_ready_i) |=>
            (rsp_valid_o && $stable(rsp_rdata_o) && $stable(rsp_err_o)))
        else $error("Response changed or dropped under back-pressure");

    assert property (@(posedge clk_i) disable iff (rst_i)
        rsp_valid_o |-> !req_ready_o)
        else $error("Request channel ready while a response is pending");

    // Registered output, cleared by the reset edge
    assert property (@(posedge clk_i) rst_i |=> (irq_o == '0))
        else $error("Interrupt output high during reset");

endmodule

bind periph_top periph_chk i_chk (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .req_valid_i ( req_valid_i ),
    .req_ready_o ( req_ready_o ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_ready_i ( rsp_ready_i ),
    .rsp_rdata_o ( rsp_rdata_o ),
    .rsp_err_o   ( rsp_err_o   ),
    .irq_o       ( irq_o       )
);

/* verification/periph_tb.sv */
`timescale 1ns/1ps

module periph_tb;

    typedef logic [periph_pkg::ADDR_WIDTH-1:0] addr_t;
    typedef logic [periph_pkg::DATA_WIDTH-1:0] data_t;

    localparam int    CLK_HALF     = 10;
    localparam int    RESET_CYCLES = 4;
    // About 90 accesses of at most 8 cycles each fit well inside this
    localparam int    CYCLE_LIMIT  = 4000;
    localparam int    MAX_POLLS    = 20;
    localparam data_t ERR          = periph_pkg::ERR_RDATA;

    logic                               clk_i;
    logic                               rst_i;
    logic                               req_valid_i;
    logic                               req_ready_o;
    logic                               req_write_i;
    addr_t                              req_addr_i;
    data_t                              req_wdata_i;
    logic                               rsp_valid_o;
    logic                               rsp_ready_i;
    data_t                              rsp_rdata_o;
    logic                               rsp_err_o;
    logic [periph_pkg::NUM_EXT_IRQ-1:0] ext_irq_i;
    logic [periph_pkg::NUM_TARGETS-1:0] irq_o;

    logic [31:0] lcg_state;
    int          cycle_count = 0;

    // Operation table, one entry per index across the queues
    string op_name  [$];
    logic  op_write [$];
    addr_t op_addr  [$];
    data_t op_wdata [$];
    data_t op_rdata [$];
    logic  op_err   [$];

    periph_top uut (.*);

    always #CLK_HALF clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            stop_with_failure();
        end
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic stop_with_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input data_t expected, input data_t actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    // Response hold-off of 0 to 3 cycles
    function automatic int unsigned next_delay();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[17:16]);
    endfunction

    function automatic addr_t reg_addr(input logic [3:0] region, input int offset);
        return {region, offset[periph_pkg::OFFSET_WIDTH-1:0]};
    endfunction

    function automatic addr_t prio_addr(input int id);
        return reg_addr(periph_pkg::REGION_PLIC, periph_pkg::PLIC_PRIO_OFS + 4 * id);
    endfunction

    function automatic addr_t pend_addr();
        return reg_addr(periph_pkg::REGION_PLIC, periph_pkg::PLIC_PEND_OFS);
    endfunction

    function automatic addr_t en_addr(input int t);
        return reg_addr(periph_pkg::REGION_PLIC, periph_pkg::PLIC_EN_OFS + 4 * t);
    endfunction

    function automatic addr_t thr_addr(input int t);
        return reg_addr(periph_pkg::REGION_PLIC, periph_pkg::PLIC_CTX_OFS + 8 * t);
    endfunction

    function automatic addr_t claim_addr(input int t);
        return reg_addr(periph_pkg::REGION_PLIC, periph_pkg::PLIC_CTX_OFS + 8 * t + 4);
    endfunction

    function automatic addr_t timer_addr(input int i, input int offset);
        return reg_addr(periph_pkg::REGION_TIMER, periph_pkg::TIMER_STRIDE * i + offset);
    endfunction

    // One access with a random delay before the response is taken
    task automatic bus_access(input logic write, input addr_t addr, input data_t wdata,
                              output data_t rdata, output logic err);
        int unsigned hold;
        req_valid_i <= 1'b1;
        req_write_i <= write;
        req_addr_i  <= addr;
        req_wdata_i <= wdata;
        do begin
            @(posedge clk_i);
        end while (!req_ready_o);
        req_valid_i <= 1'b0;
        do begin
            @(posedge clk_i);
        end while (!rsp_valid_o);
        hold = next_delay();
        repeat (hold) begin
            @(posedge clk_i);
            assert (!req_ready_o) else begin
                $display("req_ready_o went high before the response was taken");
                stop_with_failure();
            end
        end
        rdata = rsp_rdata_o;
        err   = rsp_err_o;
        rsp_ready_i <= 1'b1;
        @(posedge clk_i);
        rsp_ready_i <= 1'b0;
    endtask

    task automatic access_check(input string name, input logic write, input addr_t addr,
                                input data_t wdata, input data_t exp_rdata, input logic exp_err);
        data_t rdata;
        logic  err;
        bus_access(write, addr, wdata, rdata, err);
        check_value(name, exp_rdata, rdata);
        check_value({name, " err"}, data_t'(exp_err), data_t'(err));
    endtask

    task automatic check_irq(input string name, input logic [1:0] expected);
        check_value(name, data_t'(expected), data_t'(irq_o));
    endtask

    task automatic add_op(input string name, input logic write, input addr_t addr,
                          input data_t wdata, input data_t exp_rdata, input logic exp_err);
        op_name.push_back(name);
        op_write.push_back(write);
        op_addr.push_back(addr);
        op_wdata.push_back(wdata);
        op_rdata.push_back(exp_rdata);
        op_err.push_back(exp_err);
    endtask

    // --------------------------------------------------
    // Register and error table
    // --------------------------------------------------
    task automatic build_table();
        add_op("prio3 wr", 1'b1, prio_addr(3), 32'd5, 32'd0, 1'b0);
        add_op("prio3 rd", 1'b0, prio_addr(3), 32'd0, 32'd5, 1'b0);
        add_op("prio7 wr", 1'b1, prio_addr(7), 32'd7, 32'd0, 1'b0);
        add_op("prio7 rd", 1'b0, prio_addr(7), 32'd0, 32'd7, 1'b0);
        add_op("en1 wr", 1'b1, en_addr(1), 32'h2a, 32'd0, 1'b0);
        add_op("en1 rd", 1'b0, en_addr(1), 32'd0, 32'h2a, 1'b0);
        add_op("thr0 wr", 1'b1, thr_addr(0), 32'd3, 32'd0, 1'b0);
        add_op("thr0 rd", 1'b0, thr_addr(0), 32'd0, 32'd3, 1'b0);
        add_op("thr1 wr", 1'b1, thr_addr(1), 32'd6, 32'd0, 1'b0);
        add_op("thr1 rd", 1'b0, thr_addr(1), 32'd0, 32'd6, 1'b0);
        add_op("cmp0 wr", 1'b1, timer_addr(0, periph_pkg::TIMER_CMP_OFS), 32'h12345678, 0, 0);
        add_op("cmp0 rd", 1'b0, timer_addr(0, periph_pkg::TIMER_CMP_OFS), 0, 32'h12345678, 0);
        add_op("cmp1 wr", 1'b1, timer_addr(1, periph_pkg::TIMER_CMP_OFS), 32'hcafe0001, 0, 0);
        add_op("cmp1 rd", 1'b0, timer_addr(1, periph_pkg::TIMER_CMP_OFS), 0, 32'hcafe0001, 0);
        add_op("ctrl1 rd", 1'b0, timer_addr(1, periph_pkg::TIMER_CTRL_OFS), 0, 0, 1'b0);
        add_op("pend idle rd", 1'b0, pend_addr(), 32'd0, 32'd0, 1'b0);
        add_op("claim0 empty", 1'b0, claim_addr(0), 32'd0, 32'd0, 1'b0);
        // Regions without a peripheral
        add_op("spi rd", 1'b0, reg_addr(periph_pkg::REGION_SPI, 'h0), 0, ERR, 1'b1);
        add_op("eth wr", 1'b1, reg_addr(periph_pkg::REGION_ETH, 'h10), 1, ERR, 1'b1);
        add_op("dma rd", 1'b0, reg_addr(periph_pkg::REGION_DMA, 'h100), 0, ERR, 1'b1);
        add_op("iommu wr", 1'b1, reg_addr(periph_pkg::REGION_IOMMU, 'h4), 1, ERR, 1'b1);
        add_op("region7 rd", 1'b0, reg_addr(4'd7, 'h0), 0, ERR, 1'b1);
        // Offsets that no register decodes
        add_op("plic ofs0 wr", 1'b1, reg_addr(periph_pkg::REGION_PLIC, 'h0), 3, ERR, 1'b1);
        add_op("prio8 wr", 1'b1, prio_addr(8), 32'd3, ERR, 1'b1);
        add_op("plic ofs300 rd", 1'b0, reg_addr(periph_pkg::REGION_PLIC, 'h300), 0, ERR, 1'b1);
        add_op("timer2 cnt wr", 1'b1, timer_addr(2, periph_pkg::TIMER_CNT_OFS), 5, ERR, 1'b1);
        add_op("timer ofs2 rd", 1'b0, reg_addr(periph_pkg::REGION_TIMER, 'h2), 0, ERR, 1'b1);
        // Error writes whose offset aliases a real register
        add_op("spi alias wr", 1'b1, reg_addr(periph_pkg::REGION_SPI, 'h8), 6, ERR, 1'b1);
        add_op("prio2 kept", 1'b0, prio_addr(2), 32'd0, 32'd0, 1'b0);
        add_op("eth alias wr", 1'b1, reg_addr(periph_pkg::REGION_ETH, 'h18), 0, ERR, 1'b1);
        add_op("cmp1 kept", 1'b0, timer_addr(1, periph_pkg::TIMER_CMP_OFS), 0, 32'hcafe0001, 0);
    endtask

    initial begin
        data_t rdata;
        logic  err;
        int    polls;
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        req_addr_i  = '0;
        req_wdata_i = '0;
        rsp_ready_i = 1'b0;
        ext_irq_i   = '0;
        lcg_state   = 32'hff82;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;

        for (int i = 0; i < op_name.size(); i++) begin
            access_check(op_name[i], op_write[i], op_addr[i], op_wdata[i],
                         op_rdata[i], op_err[i]);
        end

        // Ids 3 and 4 tie at priority 5, id 5 sits below threshold 3
        access_check("prio4 wr", 1'b1, prio_addr(4), 32'd5, 32'd0, 1'b0);
        access_check("prio5 wr", 1'b1, prio_addr(5), 32'd2, 32'd0, 1'b0);
        access_check("en0 wr", 1'b1, en_addr(0), 32'h38, 32'd0, 1'b0);
        ext_irq_i <= 5'b00111;
        access_check("pend 3-5", 1'b0, pend_addr(), 32'd0, 32'h38, 1'b0);
        check_irq("irq ext", 2'b01);
        access_check("claim tie", 1'b0, claim_addr(0), 32'd0, 32'd3, 1'b0);
        access_check("pend 4-5", 1'b0, pend_addr(), 32'd0, 32'h30, 1'b0);
        access_check("claim 4", 1'b0, claim_addr(0), 32'd0, 32'd4, 1'b0);
        check_irq("irq below thr", 2'b00);
        access_check("claim 5", 1'b0, claim_addr(0), 32'd0, 32'd5, 1'b0);
        access_check("claim none", 1'b0, claim_addr(0), 32'd0, 32'd0, 1'b0);
        check_irq("irq claimed", 2'b00);

        // Claimed ids stay out of pending until completed
        access_check("pend claimed", 1'b0, pend_addr(), 32'd0, 32'd0, 1'b0);
        access_check("complete 3", 1'b1, claim_addr(0), 32'd3, 32'd0, 1'b0);
        access_check("pend re-arm", 1'b0, pend_addr(), 32'd0, 32'h08, 1'b0);
        ext_irq_i <= '0;
        access_check("complete 4", 1'b1, claim_addr(0), 32'd4, 32'd0, 1'b0);
        access_check("complete 5", 1'b1, claim_addr(0), 32'd5, 32'd0, 1'b0);
        access_check("pend only 3", 1'b0, pend_addr(), 32'd0, 32'h08, 1'b0);
        access_check("claim 3 again", 1'b0, claim_addr(0), 32'd0, 32'd3, 1'b0);
        access_check("complete 3 again", 1'b1, claim_addr(0), 32'd3, 32'd0, 1'b0);
        access_check("pend clear", 1'b0, pend_addr(), 32'd0, 32'd0, 1'b0);

        // --------------------------------------------------
        // Timer 0 through the PLIC to target 0
        // --------------------------------------------------
        access_check("prio1 wr", 1'b1, prio_addr(1), 32'd4, 32'd0, 1'b0);
        access_check("en0 timer", 1'b1, en_addr(0), 32'h02, 32'd0, 1'b0);
        access_check("cmp0 small", 1'b1, timer_addr(0, periph_pkg::TIMER_CMP_OFS), 5, 0, 0);
        access_check("ctrl0 on", 1'b1, timer_addr(0, periph_pkg::TIMER_CTRL_OFS), 1, 0, 0);
        polls = 0;
        do begin
            bus_access(1'b0, timer_addr(0, periph_pkg::TIMER_STAT_OFS), '0, rdata, err);
            polls++;
        end while (rdata != 32'd1 && polls < MAX_POLLS);
        assert (rdata == 32'd1) else begin
            $display("Timer 0 status did not set within %0d polls", MAX_POLLS);
            stop_with_failure();
        end
        access_check("pend timer", 1'b0, pend_addr(), 32'd0, 32'h02, 1'b0);
        // Target 1 also enables id 1, but priority 4 is not above threshold 6
        check_irq("irq timer", 2'b01);
        // Threshold 3 on target 1 lets priority 4 through there too
        access_check("thr1 low", 1'b1, thr_addr(1), 32'd3, 32'd0, 1'b0);
        check_irq("irq timer both", 2'b11);
        access_check("claim timer", 1'b0, claim_addr(0), 32'd0, 32'd1, 1'b0);
        access_check("ctrl0 off", 1'b1, timer_addr(0, periph_pkg::TIMER_CTRL_OFS), 0, 0, 0);
        access_check("stat0 clear", 1'b1, timer_addr(0, periph_pkg::TIMER_STAT_OFS), 1, 0, 0);
        access_check("stat0 rd", 1'b0, timer_addr(0, periph_pkg::TIMER_STAT_OFS), 0, 0, 0);
        access_check("complete 1", 1'b1, claim_addr(0), 32'd1, 32'd0, 1'b0);
        access_check("pend done", 1'b0, pend_addr(), 32'd0, 32'd0, 1'b0);
        check_irq("irq done", 2'b00);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* list.f */
verilog/periph_pkg.sv
verilog/reg_bus_if.sv
verilog/periph_bridge.sv
verilog/periph_plic.sv
verilog/periph_timer.sv
verilog/periph_top.sv
verification/periph_chk.sv
verification/periph_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the peripheral subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -f list.f --top-module periph_tb \
    -Mdir "$BUILD_DIR" -o periph_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/periph_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q -F "*** TEST PASSED ***" "$LOG_FILE"; then
    echo "Simulation passed"
    exit 0
else
    echo "Pass message not found in $LOG_FILE"
    exit 1
fi
